// File: logic/alu_pkg.sv
package alu_pkg;

    localparam int dat_bits       = 16;
    localparam int main_addr_bits = 4;
    localparam int unit_addr_bits = 3;

    typedef logic [dat_bits-1:0]       word_t;
    typedef logic [main_addr_bits-1:0] main_addr_t;
    typedef logic [unit_addr_bits-1:0] unit_addr_t;

    // Operand source of a unit, code 7 reads as zero
    typedef enum logic [2:0] {
        SRC_MM_MEM   = 3'd0,
        SRC_MM_SC    = 3'd1,
        SRC_MM_REG   = 3'd2,
        SRC_MAS_MEM  = 3'd3,
        SRC_MAS_SC   = 3'd4,
        SRC_MAS_REG  = 3'd5,
        SRC_MAIN_MEM = 3'd6
    } src_t;

    // Main memory write data
    typedef enum logic [1:0] {
        WB_NONE = 2'd0,
        WB_MM   = 2'd1,
        WB_MAS  = 2'd2
    } main_src_t;

    typedef struct packed {
        main_addr_t main_raddr_a;
        main_addr_t main_raddr_b;
        main_addr_t main_waddr;
        logic       main_we;
        main_src_t  main_src;
        unit_addr_t mm_raddr_a;
        unit_addr_t mm_raddr_b;
        src_t       mm_src_a;
        src_t       mm_src_b;
        logic       mm_val;
        logic       mm_we;
        unit_addr_t mm_waddr;
        unit_addr_t mas_raddr_a;
        unit_addr_t mas_raddr_b;
        src_t       mas_src_a;
        src_t       mas_src_b;
        logic       mas_val;
        logic       mas_issub;
        logic       mas_we;
        unit_addr_t mas_waddr;
    } inst_t;

    // Local write-back target, follows the operation down the pipe
    typedef struct packed {
        logic       we;
        unit_addr_t waddr;
    } ret_tag_t;

    typedef struct packed {
        word_t main_a;
        word_t main_b;
        word_t mm_a;
        word_t mm_b;
        word_t mas_a;
        word_t mas_b;
        word_t mm_dout;
        word_t mm_dout_reg;
        word_t mas_dout;
        word_t mas_dout_reg;
    } opnd_bus_t;

    // Memory sources use the read port that matches the operand side
    function automatic word_t pick_opnd(src_t src, opnd_bus_t bus, logic port_b);
        word_t sel;
        case (src)
            SRC_MM_MEM:   sel = port_b ? bus.mm_b : bus.mm_a;
            SRC_MM_SC:    sel = bus.mm_dout;
            SRC_MM_REG:   sel = bus.mm_dout_reg;
            SRC_MAS_MEM:  sel = port_b ? bus.mas_b : bus.mas_a;
            SRC_MAS_SC:   sel = bus.mas_dout;
            SRC_MAS_REG:  sel = bus.mas_dout_reg;
            SRC_MAIN_MEM: sel = port_b ? bus.main_b : bus.main_a;
            default:      sel = '0;
        endcase
        return sel;
    endfunction

endpackage

// File: logic/ram_2r1w.sv
`timescale 1ns/1ns

module ram_2r1w
    import alu_pkg::*;
#(
    parameter  int DEPTH     = 8,
    localparam int ADDR_BITS = $clog2(DEPTH)
) (
    input  logic                 clk,
    input  logic [ADDR_BITS-1:0] raddr_a,
    input  logic [ADDR_BITS-1:0] raddr_b,
    input  logic                 we,
    input  logic [ADDR_BITS-1:0] waddr,
    input  word_t                din,
    output word_t                dout_a,
    output word_t                dout_b
);

    word_t mem [DEPTH];

    // Reads see the contents from before a same-edge write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;
        end
        dout_a <= mem[raddr_a];
        dout_b <= mem[raddr_b];
    end

endmodule

// File: logic/stage_pipe.sv
`timescale 1ns/1ns

module stage_pipe #(
    parameter type T      = logic,
    parameter int  STAGES = 1
) (
    input  logic clk,
    input  logic rst,
    input  T     din,
    output T     dout
);

    T pipe_q [STAGES];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < STAGES; i++) begin
                pipe_q[i] <= '0;
            end
        end else begin
            pipe_q[0] <= din;
            for (int i = 1; i < STAGES; i++) begin
                pipe_q[i] <= pipe_q[i-1];
            end
        end
    end

    assign dout = pipe_q[STAGES-1];

endmodule

// File: logic/mod_mul_unit.sv
`timescale 1ns/1ns

module mod_mul_unit
    import alu_pkg::*;
#(
    parameter int          DAT_BITS = 16,
    parameter int unsigned MODULUS  = 65521
) (
    input  logic       clk,
    input  logic       rst,
    input  unit_addr_t raddr_a,
    input  unit_addr_t raddr_b,
    input  src_t       src_a,
    input  src_t       src_b,
    input  logic       val,
    input  logic       we,
    input  unit_addr_t waddr,
    input  opnd_bus_t  opnd,
    output word_t      mem_a,
    output word_t      mem_b,
    output word_t      dout,
    output word_t      dout_reg,
    output logic       oval
);

    localparam logic [2*DAT_BITS-1:0] MOD_W = (2*DAT_BITS)'(MODULUS);

    word_t                 opnd_a;
    word_t                 opnd_b;
    logic [DAT_BITS-1:0]   a_q;
    logic [DAT_BITS-1:0]   b_q;
    logic [2*DAT_BITS-1:0] prod;
    logic [DAT_BITS-1:0]   red_q;
    logic [2:0]            vld_q;
    ret_tag_t              tag_in;
    ret_tag_t              tag_out;

    ram_2r1w #(.DEPTH(2**unit_addr_bits)) mem_i (
        .clk     (clk),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .we      (oval & tag_out.we),
        .waddr   (tag_out.waddr),
        .din     (dout),
        .dout_a  (mem_a),
        .dout_b  (mem_b)
    );

    assign opnd_a = pick_opnd(src_a, opnd, 1'b0);
    assign opnd_b = pick_opnd(src_b, opnd, 1'b1);

    // Tag rides alongside the three arithmetic stages
    assign tag_in = '{we: we, waddr: waddr};

    stage_pipe #(.T(ret_tag_t), .STAGES(3)) tag_pipe_i (
        .clk  (clk),
        .rst  (rst),
        .din  (tag_in),
        .dout (tag_out)
    );

    assign prod = a_q * b_q;

    // Operand capture, then reduction
    always_ff @(posedge clk) begin
        a_q   <= opnd_a;
        b_q   <= opnd_b;
        red_q <= DAT_BITS'(prod % MOD_W);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_q    <= '0;
            dout     <= '0;
            dout_reg <= '0;
        end else begin
            vld_q <= {vld_q[1:0], val};
            // Result holds between operations
            if (vld_q[1]) begin
                dout <= red_q;
            end
            dout_reg <= dout;
        end
    end

    assign oval = vld_q[2];

endmodule

// File: logic/mod_addsub_unit.sv
`timescale 1ns/1ns

module mod_addsub_unit
    import alu_pkg::*;
#(
    parameter int          DAT_BITS = 16,
    parameter int unsigned MODULUS  = 65521
) (
    input  logic       clk,
    input  logic       rst,
    input  unit_addr_t raddr_a,
    input  unit_addr_t raddr_b,
    input  src_t       src_a,
    input  src_t       src_b,
    input  logic       val,
    input  logic       issub,
    input  logic       we,
    input  unit_addr_t waddr,
    input  opnd_bus_t  opnd,
    output word_t      mem_a,
    output word_t      mem_b,
    output word_t      dout,
    output word_t      dout_reg,
    output logic       oval
);

    localparam logic [DAT_BITS:0] MOD_W = (DAT_BITS+1)'(MODULUS);

    word_t             opnd_a;
    word_t             opnd_b;
    logic [DAT_BITS:0] sum;
    logic [DAT_BITS:0] diff;
    logic [DAT_BITS:0] res;
    ret_tag_t          tag_q;

    ram_2r1w #(.DEPTH(2**unit_addr_bits)) mem_i (
        .clk     (clk),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .we      (oval & tag_q.we),
        .waddr   (tag_q.waddr),
        .din     (dout),
        .dout_a  (mem_a),
        .dout_b  (mem_b)
    );

    assign opnd_a = pick_opnd(src_a, opnd, 1'b0);
    assign opnd_b = pick_opnd(src_b, opnd, 1'b1);

    // Operands are below the modulus, so one correction step is enough
    always_comb begin
        sum  = {1'b0, opnd_a} + {1'b0, opnd_b};
        diff = {1'b0, opnd_a} - {1'b0, opnd_b};
        if (issub) begin
            // Top bit set means the difference went negative
            res = diff[DAT_BITS] ? diff + MOD_W : diff;
        end else begin
            res = (sum >= MOD_W) ? sum - MOD_W : sum;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            oval     <= 1'b0;
            tag_q    <= '0;
            dout     <= '0;
            dout_reg <= '0;
        end else begin
            oval  <= val;
            tag_q <= '{we: we, waddr: waddr};
            if (val) begin
                dout <= res[DAT_BITS-1:0];
            end
            dout_reg <= dout;
        end
    end

endmodule

// File: logic/main_store.sv
`timescale 1ns/1ns

module main_store
    import alu_pkg::*;
#(
    parameter int DAT_BITS = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  main_addr_t raddr_a,
    input  main_addr_t raddr_b,
    input  main_addr_t waddr,
    input  logic       we,
    input  main_src_t  src,
    input  logic       load_en,
    input  word_t      load_data,
    input  word_t      mm_dout,
    input  word_t      mas_dout,
    output word_t      mem_a,
    output word_t      mem_b,
    output word_t      dout
);

    logic [DAT_BITS-1:0] load_q;
    logic                load_en_q;
    word_t               wdata;

    // Load word lines up with the instruction in its second cycle
    always_ff @(posedge clk) begin
        load_q <= load_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_en_q <= 1'b0;
            dout      <= '0;
        end else begin
            load_en_q <= load_en;
            dout      <= mem_b;
        end
    end

    // External load wins over unit results
    always_comb begin
        if (load_en_q) begin
            wdata = load_q;
        end else begin
            case (src)
                WB_MM:   wdata = mm_dout;
                WB_MAS:  wdata = mas_dout;
                default: wdata = '0;
            endcase
        end
    end

    ram_2r1w #(.DEPTH(2**main_addr_bits)) mem_i (
        .clk     (clk),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .we      (we),
        .waddr   (waddr),
        .din     (wdata),
        .dout_a  (mem_a),
        .dout_b  (mem_b)
    );

endmodule

// File: logic/alu_core.sv
`timescale 1ns/1ns

module alu_core
    import alu_pkg::*;
#(
    parameter int          DAT_BITS = 16,
    parameter int unsigned MODULUS  = 65521
) (
    input  logic  clk,
    input  logic  rst,
    input  inst_t inst,
    input  logic  load_en,
    input  word_t load_data,
    output word_t dout
);

    inst_t     inst_q;
    opnd_bus_t opnd;
    logic      mm_oval;
    logic      mas_oval;

    // Read addresses come from inst, all other fields from inst_q
    stage_pipe #(.T(inst_t), .STAGES(1)) inst_pipe_i (
        .clk  (clk),
        .rst  (rst),
        .din  (inst),
        .dout (inst_q)
    );

    mod_mul_unit #(.DAT_BITS(DAT_BITS), .MODULUS(MODULUS)) mm_i (
        .clk      (clk),
        .rst      (rst),
        .raddr_a  (inst.mm_raddr_a),
        .raddr_b  (inst.mm_raddr_b),
        .src_a    (inst_q.mm_src_a),
        .src_b    (inst_q.mm_src_b),
        .val      (inst_q.mm_val),
        .we       (inst_q.mm_we),
        .waddr    (inst_q.mm_waddr),
        .opnd     (opnd),
        .mem_a    (opnd.mm_a),
        .mem_b    (opnd.mm_b),
        .dout     (opnd.mm_dout),
        .dout_reg (opnd.mm_dout_reg),
        .oval     (mm_oval)
    );

    mod_addsub_unit #(.DAT_BITS(DAT_BITS), .MODULUS(MODULUS)) mas_i (
        .clk      (clk),
        .rst      (rst),
        .raddr_a  (inst.mas_raddr_a),
        .raddr_b  (inst.mas_raddr_b),
        .src_a    (inst_q.mas_src_a),
        .src_b    (inst_q.mas_src_b),
        .val      (inst_q.mas_val),
        .issub    (inst_q.mas_issub),
        .we       (inst_q.mas_we),
        .waddr    (inst_q.mas_waddr),
        .opnd     (opnd),
        .mem_a    (opnd.mas_a),
        .mem_b    (opnd.mas_b),
        .dout     (opnd.mas_dout),
        .dout_reg (opnd.mas_dout_reg),
        .oval     (mas_oval)
    );

    main_store #(.DAT_BITS(DAT_BITS)) main_i (
        .clk       (clk),
        .rst       (rst),
        .raddr_a   (inst.main_raddr_a),
        .raddr_b   (inst.main_raddr_b),
        .waddr     (inst_q.main_waddr),
        .we        (inst_q.main_we),
        .src       (inst_q.main_src),
        .load_en   (load_en),
        .load_data (load_data),
        .mm_dout   (opnd.mm_dout),
        .mas_dout  (opnd.mas_dout),
        .mem_a     (opnd.main_a),
        .mem_b     (opnd.main_b),
        .dout      (dout)
    );

endmodule

// File: sim/alu_core_asserts.sv
`timescale 1ns/1ns

module alu_core_asserts
    import alu_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  mm_val,
    input logic  mm_oval,
    input logic  mas_val,
    input logic  mas_oval,
    input word_t dout
);

    // Multiplier result strobe after three edges
    mm_latency_a: assert property (@(posedge clk) disable iff (rst)
        mm_val |-> ##3 mm_oval)
        else $error("mm_oval missing three cycles after mm_val");

    mas_latency_a: assert property (@(posedge clk) disable iff (rst)
        mas_val |=> mas_oval)
        else $error("mas_oval missing one cycle after mas_val");

    // Readout register comes out of reset cleared
    dout_reset_a: assert property (@(posedge clk)
        $fell(rst) |-> dout == '0)
        else $error("dout not zero after reset");

endmodule

bind alu_core alu_core_asserts asserts_i (
    .clk      (clk),
    .rst      (rst),
    .mm_val   (inst_q.mm_val),
    .mm_oval  (mm_oval),
    .mas_val  (inst_q.mas_val),
    .mas_oval (mas_oval),
    .dout     (dout)
);

// File: sim/tb_alu_core.sv
`timescale 1ns/1ns

module tb_alu_core
    import alu_pkg::*;
;

    localparam int          PERIOD     = 100;
    localparam int          RST_CYCLES = 10;
    localparam int unsigned MOD        = 65521;
    localparam int          OP_CYCLES  = 8;
    localparam int          N_MUL      = 20;
    localparam int          N_ADD      = 20;
    localparam int          N_MIX      = 60;
    // Loads, readouts, fill, unit tests with move and readout, mix and priority check
    localparam int N_OPS = 16 + 16 + 16 + 3 * N_MUL + 3 * N_ADD + N_MIX + 2;
    localparam longint LIMIT = 2 * longint'(RST_CYCLES + N_OPS * OP_CYCLES) * PERIOD;

    logic  clk;
    logic  rst;
    inst_t inst;
    logic  load_en;
    word_t load_data;
    word_t dout;

    integer seed = 32'h869cde8c;

    // Reference state
    word_t main_mem [16];
    logic  main_ok  [16];
    word_t mm_mem   [8];
    word_t mas_mem  [8];
    word_t mm_res;
    word_t mm_reg;
    word_t mas_res;
    word_t mas_reg;

    alu_core #(.DAT_BITS(16), .MODULUS(MOD)) dut_i (
        .clk       (clk),
        .rst       (rst),
        .inst      (inst),
        .load_en   (load_en),
        .load_data (load_data),
        .dout      (dout)
    );

    always #(PERIOD / 2) clk = ~clk;

    initial begin
        #(LIMIT);
        $display("Run did not finish within the expected time");
        $display("Verification failed");
        $fatal(1);
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("Error %s expected %h actual %h", name, exp, act);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    function automatic word_t rand_word();
        return word_t'($unsigned($random(seed)) % MOD);
    endfunction

    // Each memory is read at its own read address, whichever unit takes the word
    function automatic word_t model_operand(src_t src, inst_t i, logic port_b);
        case (src)
            SRC_MM_MEM:   return mm_mem[port_b ? i.mm_raddr_b : i.mm_raddr_a];
            SRC_MAS_MEM:  return mas_mem[port_b ? i.mas_raddr_b : i.mas_raddr_a];
            SRC_MAIN_MEM: return main_mem[port_b ? i.main_raddr_b : i.main_raddr_a];
            SRC_MM_SC:    return mm_res;
            SRC_MM_REG:   return mm_reg;
            SRC_MAS_SC:   return mas_res;
            SRC_MAS_REG:  return mas_reg;
            default:      return '0;
        endcase
    endfunction

    task automatic apply_model(input inst_t i, input logic ld, input word_t ld_data);
        int unsigned a;
        int unsigned b;
        word_t       mm_new;
        word_t       mas_new;
        word_t       wdata;
        a = model_operand(i.mm_src_a, i, 1'b0);
        b = model_operand(i.mm_src_b, i, 1'b1);
        mm_new = word_t'((longint'(a) * longint'(b)) % MOD);
        a = model_operand(i.mas_src_a, i, 1'b0);
        b = model_operand(i.mas_src_b, i, 1'b1);
        if (i.mas_issub) begin
            mas_new = word_t'((a >= b) ? a - b : a + MOD - b);
        end else begin
            mas_new = word_t'((a + b >= MOD) ? a + b - MOD : a + b);
        end
        // Main write sees the unit results from before this instruction
        if (ld) begin
            wdata = ld_data;
        end else if (i.main_src == WB_MM) begin
            wdata = mm_res;
        end else if (i.main_src == WB_MAS) begin
            wdata = mas_res;
        end else begin
            wdata = '0;
        end
        if (i.main_we) begin
            main_mem[i.main_waddr] = wdata;
            main_ok[i.main_waddr] = 1'b1;
        end
        if (i.mm_val) begin
            mm_res = mm_new;
            if (i.mm_we) begin
                mm_mem[i.mm_waddr] = mm_new;
            end
        end
        if (i.mas_val) begin
            mas_res = mas_new;
            if (i.mas_we) begin
                mas_mem[i.mas_waddr] = mas_new;
            end
        end
        mm_reg = mm_res;
        mas_reg = mas_res;
    endtask

    // One instruction, readout check two edges later, then idle until all latencies end
    task automatic run_inst(input inst_t i, input logic ld, input word_t ld_data);
        word_t exp_rd;
        logic  rd_ok;
        exp_rd = main_mem[i.main_raddr_b];
        rd_ok = main_ok[i.main_raddr_b];
        @(negedge clk);
        inst = i;
        load_en = ld;
        load_data = ld_data;
        @(negedge clk);
        inst = '0;
        load_en = 1'b0;
        load_data = '0;
        @(negedge clk);
        if (rd_ok) begin
            check_word("dout", exp_rd, dout);
        end
        repeat (OP_CYCLES - 3) @(negedge clk);
        apply_model(i, ld, ld_data);
    endtask

    task automatic readout(input main_addr_t addr);
        inst_t i;
        i = '0;
        i.main_raddr_b = addr;
        run_inst(i, 1'b0, '0);
    endtask

    task automatic unit_op(input logic use_mm, input logic use_rand_addr, input int k);
        inst_t i;
        i = '0;
        i.main_raddr_a = main_addr_t'($random(seed));
        i.main_raddr_b = main_addr_t'($random(seed));
        if (use_mm) begin
            i.mm_src_a = SRC_MAIN_MEM;
            i.mm_src_b = SRC_MAIN_MEM;
            i.mm_val = 1'b1;
            i.mm_we = 1'b1;
            i.mm_waddr = use_rand_addr ? unit_addr_t'($random(seed)) : unit_addr_t'(k);
        end else begin
            i.mas_src_a = SRC_MAIN_MEM;
            i.mas_src_b = SRC_MAIN_MEM;
            i.mas_val = 1'b1;
            i.mas_issub = use_rand_addr ? 1'($random(seed)) : 1'b0;
            i.mas_we = 1'b1;
            i.mas_waddr = use_rand_addr ? unit_addr_t'($random(seed)) : unit_addr_t'(k);
        end
        run_inst(i, 1'b0, '0);
    endtask

    task automatic move_result(input main_src_t src);
        inst_t i;
        i = '0;
        i.main_we = 1'b1;
        i.main_src = src;
        i.main_waddr = main_addr_t'($random(seed));
        i.main_raddr_b = main_addr_t'($random(seed));
        run_inst(i, 1'b0, '0);
        readout(i.main_waddr);
    endtask

    task automatic mixed_op();
        inst_t       i;
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        i = r[$bits(inst_t)-1:0];
        run_inst(i, 1'b0, '0);
    endtask

    initial begin
        inst_t i;
        clk = 1'b0;
        rst = 1'b1;
        inst = '0;
        load_en = 1'b0;
        load_data = '0;
        mm_res = '0;
        mm_reg = '0;
        mas_res = '0;
        mas_reg = '0;
        for (int k = 0; k < 16; k++) begin
            main_ok[k] = 1'b0;
        end
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;

        // Load every main address, then read back
        for (int k = 0; k < 16; k++) begin
            i = '0;
            i.main_we = 1'b1;
            i.main_waddr = main_addr_t'(k);
            run_inst(i, 1'b1, rand_word());
        end
        for (int k = 0; k < 16; k++) begin
            readout(main_addr_t'($random(seed)));
        end

        // Give both local memories defined contents
        for (int k = 0; k < 8; k++) begin
            unit_op(1'b1, 1'b0, k);
            unit_op(1'b0, 1'b0, k);
        end

        for (int k = 0; k < N_MUL; k++) begin
            unit_op(1'b1, 1'b1, k);
            move_result(WB_MM);
        end
        for (int k = 0; k < N_ADD; k++) begin
            unit_op(1'b0, 1'b1, k);
            move_result(WB_MAS);
        end

        // Cross, local, shortcut and register sources
        for (int k = 0; k < N_MIX; k++) begin
            mixed_op();
        end

        // Load wins over a unit result on the same write
        i = '0;
        i.main_we = 1'b1;
        i.main_src = WB_MM;
        i.main_waddr = main_addr_t'($random(seed));
        run_inst(i, 1'b1, rand_word());
        readout(i.main_waddr);

        $display("Verification passed");
        $finish;
    end

endmodule

// File: src.f
logic/alu_pkg.sv
logic/ram_2r1w.sv
logic/stage_pipe.sv
logic/mod_mul_unit.sv
logic/mod_addsub_unit.sv
logic/main_store.sv
logic/alu_core.sv
sim/alu_core_asserts.sv
sim/tb_alu_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_alu_core
BUILD_DIR ?= build
SEED_ARGS ?=

VFLAGS = --timing --assert --top-module $(TOP) -f src.f

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

sim:
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(BUILD_DIR)
